//--- design/hsiao_dec.sv
// hsiao_dec: Hsiao SECDED syndrome, single-bit correction and error classification
`timescale 1ns/1ps
`default_nettype none

module hsiao_dec #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7
) (
  input  wire logic [DataWidth-1:0] data_i,
  input  wire logic [ProtWidth-1:0] ecc_i,
  output logic      [DataWidth-1:0] data_o,
  output logic                      single_err_o,
  output logic                      multi_err_o
);

  import tcdm_ecc_pkg::*;

  logic [ProtWidth-1:0][DataWidth-1:0] row_sel;
  logic [ProtWidth-1:0]                ecc_calc;
  logic [ProtWidth-1:0]                syndrome;
  logic [DataWidth-1:0]                flip;
  logic                                syn_odd;
  logic                                data_hit;
  logic                                check_hit;

  // recompute the check bits from the received data
  for (genvar i = 0; i < DataWidth; i++) begin : g_col
    localparam logic [7:0] COL = hsiao_col(i, ProtWidth);

    for (genvar k = 0; k < ProtWidth; k++) begin : g_row
      assign row_sel[k][i] = COL[k] & data_i[i];
    end

    // syndrome equal to this column points at data bit i
    assign flip[i] = (syndrome == COL[ProtWidth-1:0]);
  end

  for (genvar k = 0; k < ProtWidth; k++) begin : g_parity
    assign ecc_calc[k] = ^row_sel[k];
  end

  assign syndrome = ecc_calc ^ ecc_i;

  assign syn_odd   = ^syndrome;
  assign data_hit  = |flip;
  // a weight-1 syndrome is a flipped check bit, data stays as is
  assign check_hit = ($countones(syndrome) == 1);

  assign data_o = data_i ^ flip;

  assign single_err_o = syn_odd & (data_hit | check_hit);
  // even nonzero syndrome, or an odd one that matches no column
  assign multi_err_o  = (syndrome != '0) & ~single_err_o;

endmodule

`default_nettype wire

//--- design/hsiao_enc.sv
// hsiao_enc: Hsiao SECDED check-bit generator
`timescale 1ns/1ps
`default_nettype none

module hsiao_enc #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7
) (
  input  wire logic [DataWidth-1:0] data_i,
  output logic      [ProtWidth-1:0] ecc_o
);

  import tcdm_ecc_pkg::*;

  // data bits selected into each check row
  logic [ProtWidth-1:0][DataWidth-1:0] row_sel;

  for (genvar i = 0; i < DataWidth; i++) begin : g_col
    localparam logic [7:0] COL = hsiao_col(i, ProtWidth);

    for (genvar k = 0; k < ProtWidth; k++) begin : g_row
      assign row_sel[k][i] = COL[k] & data_i[i];
    end
  end

  // one parity tree per check bit
  for (genvar k = 0; k < ProtWidth; k++) begin : g_parity
    assign ecc_o[k] = ^row_sel[k];
  end

endmodule

`default_nettype wire

//--- design/tcdm_bus_pkg.sv
// tcdm_bus_pkg: bus geometry constants and arbiter state enum
`default_nettype none

package tcdm_bus_pkg;

  // initiator ports sharing the bank
  localparam int unsigned N_PORTS = 2;

  // word address, 256 words
  localparam int unsigned ADDR_W = 8;

  // one 32-bit chunk per word
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // metadata covered by the metadata check bits, packed as {add, wen, be}
  localparam int unsigned META_W = ADDR_W + 1 + BE_W;

  // port granted on the last arbitration
  typedef enum logic {
    LAST_P0 = 1'b0,
    LAST_P1 = 1'b1
  } arb_last_e;

endpackage

`default_nettype wire

//--- design/tcdm_ecc_dec.sv
// tcdm_ecc_dec: per-port request SECDED decoder and response check-bit encoder
`timescale 1ns/1ps
`default_nettype none

module tcdm_ecc_dec (
  // initiator side
  input  wire logic                               req_i,
  output logic                                    gnt_o,
  input  wire logic [tcdm_bus_pkg::ADDR_W-1:0]    add_i,
  input  wire logic                               wen_i,
  input  wire logic [tcdm_bus_pkg::BE_W-1:0]      be_i,
  input  wire logic [tcdm_bus_pkg::DATA_W-1:0]    data_i,
  input  wire logic [tcdm_ecc_pkg::REQ_ECC_W-1:0] ecc_i,
  output logic                                    r_valid_o,
  output logic      [tcdm_bus_pkg::DATA_W-1:0]    r_data_o,
  output logic      [tcdm_ecc_pkg::DATA_ECC_W-1:0] r_ecc_o,
  // arbiter side
  output logic                                    req_o,
  input  wire logic                               gnt_i,
  output logic      [tcdm_bus_pkg::ADDR_W-1:0]    add_o,
  output logic                                    wen_o,
  output logic      [tcdm_bus_pkg::BE_W-1:0]      be_o,
  output logic      [tcdm_bus_pkg::DATA_W-1:0]    data_o,
  input  wire logic                               r_valid_i,
  input  wire logic [tcdm_bus_pkg::DATA_W-1:0]    r_data_i,
  // error flags, valid while req_i is high
  output logic                                    data_single_err_o,
  output logic                                    data_multi_err_o,
  output logic                                    meta_single_err_o,
  output logic                                    meta_multi_err_o
);

  import tcdm_bus_pkg::*;
  import tcdm_ecc_pkg::*;

  logic [DATA_ECC_W-1:0] data_ecc;
  logic [META_ECC_W-1:0] meta_ecc;
  logic [META_W-1:0]     meta_dec;

  // check bits of the data sit above those of the metadata
  assign data_ecc = ecc_i[REQ_ECC_W-1:META_ECC_W];
  assign meta_ecc = ecc_i[META_ECC_W-1:0];

  hsiao_dec #(
    .DataWidth ( DATA_W     ),
    .ProtWidth ( DATA_ECC_W )
  ) i_data_dec (
    .data_i       ( data_i            ),
    .ecc_i        ( data_ecc          ),
    .data_o       ( data_o            ),
    .single_err_o ( data_single_err_o ),
    .multi_err_o  ( data_multi_err_o  )
  );

  // metadata word is {add, wen, be}
  hsiao_dec #(
    .DataWidth ( META_W     ),
    .ProtWidth ( META_ECC_W )
  ) i_meta_dec (
    .data_i       ( {add_i, wen_i, be_i} ),
    .ecc_i        ( meta_ecc             ),
    .data_o       ( meta_dec             ),
    .single_err_o ( meta_single_err_o    ),
    .multi_err_o  ( meta_multi_err_o     )
  );

  assign {add_o, wen_o, be_o} = meta_dec;

  // check bits for the read data going back
  hsiao_enc #(
    .DataWidth ( DATA_W     ),
    .ProtWidth ( DATA_ECC_W )
  ) i_r_data_enc (
    .data_i ( r_data_i ),
    .ecc_o  ( r_ecc_o  )
  );

  assign req_o     = req_i;
  assign gnt_o     = gnt_i;
  assign r_valid_o = r_valid_i;
  assign r_data_o  = r_data_i;

endmodule

`default_nettype wire

//--- design/tcdm_ecc_pkg.sv
// tcdm_ecc_pkg: SECDED check widths and the Hsiao column function
`default_nettype none

package tcdm_ecc_pkg;

  // clog2(width) + 2 check bits per protected field
  localparam int unsigned DATA_ECC_W = 7;
  localparam int unsigned META_ECC_W = 6;

  // request check bits, data check above metadata check
  localparam int unsigned REQ_ECC_W = DATA_ECC_W + META_ECC_W;

  // column of the parity check matrix for data bit idx
  // weight-1 columns belong to the check bits, so data columns start at weight 3
  // and go through the odd weights in increasing order, smallest value first
  function automatic logic [7:0] hsiao_col(input int unsigned idx, input int unsigned width);
    int unsigned cnt;
    logic [7:0]  col;
    cnt = 0;
    col = '0;
    for (int unsigned w = 3; w <= width; w += 2) begin
      for (int unsigned v = 0; v < (1 << width); v++) begin
        if ($countones(v) == w) begin
          if (cnt == idx) begin
            col = v[7:0];
          end
          cnt++;
        end
      end
    end
    return col;
  endfunction

endpackage

`default_nettype wire

//--- design/tcdm_ecc_top.sv
// tcdm_ecc_top: two request decoders, round-robin arbiter and SRAM bank
`timescale 1ns/1ps
`default_nettype none

module tcdm_ecc_top (
  input  wire logic                                                            clk_i,
  input  wire logic                                                            rst_n_i,
  input  wire logic [tcdm_bus_pkg::N_PORTS-1:0]                                req_i,
  output logic      [tcdm_bus_pkg::N_PORTS-1:0]                                gnt_o,
  input  wire logic [tcdm_bus_pkg::N_PORTS-1:0][tcdm_bus_pkg::ADDR_W-1:0]      add_i,
  input  wire logic [tcdm_bus_pkg::N_PORTS-1:0]                                wen_i,
  input  wire logic [tcdm_bus_pkg::N_PORTS-1:0][tcdm_bus_pkg::BE_W-1:0]        be_i,
  input  wire logic [tcdm_bus_pkg::N_PORTS-1:0][tcdm_bus_pkg::DATA_W-1:0]      data_i,
  input  wire logic [tcdm_bus_pkg::N_PORTS-1:0][tcdm_ecc_pkg::REQ_ECC_W-1:0]   ecc_i,
  output logic      [tcdm_bus_pkg::N_PORTS-1:0]                                r_valid_o,
  output logic      [tcdm_bus_pkg::N_PORTS-1:0][tcdm_bus_pkg::DATA_W-1:0]      r_data_o,
  output logic      [tcdm_bus_pkg::N_PORTS-1:0][tcdm_ecc_pkg::DATA_ECC_W-1:0]  r_ecc_o,
  output logic      [tcdm_bus_pkg::N_PORTS-1:0]                                data_single_err_o,
  output logic      [tcdm_bus_pkg::N_PORTS-1:0]                                data_multi_err_o,
  output logic      [tcdm_bus_pkg::N_PORTS-1:0]                                meta_single_err_o,
  output logic      [tcdm_bus_pkg::N_PORTS-1:0]                                meta_multi_err_o
);

  import tcdm_bus_pkg::*;

  // corrected requests toward the arbiter
  logic [N_PORTS-1:0]             arb_req;
  logic [N_PORTS-1:0]             arb_gnt;
  logic [N_PORTS-1:0][ADDR_W-1:0] arb_add;
  logic [N_PORTS-1:0]             arb_wen;
  logic [N_PORTS-1:0][BE_W-1:0]   arb_be;
  logic [N_PORTS-1:0][DATA_W-1:0] arb_data;
  logic [N_PORTS-1:0]             arb_r_valid;
  logic [N_PORTS-1:0][DATA_W-1:0] arb_r_data;

  // bank interface
  logic              bank_req;
  logic [ADDR_W-1:0] bank_add;
  logic              bank_wen;
  logic [BE_W-1:0]   bank_be;
  logic [DATA_W-1:0] bank_data;
  logic              bank_r_valid;
  logic [DATA_W-1:0] bank_r_data;

  for (genvar p = 0; p < N_PORTS; p++) begin : g_port
    tcdm_ecc_dec i_ecc_dec (
      .req_i             ( req_i[p]             ),
      .gnt_o             ( gnt_o[p]             ),
      .add_i             ( add_i[p]             ),
      .wen_i             ( wen_i[p]             ),
      .be_i              ( be_i[p]              ),
      .data_i            ( data_i[p]            ),
      .ecc_i             ( ecc_i[p]             ),
      .r_valid_o         ( r_valid_o[p]         ),
      .r_data_o          ( r_data_o[p]          ),
      .r_ecc_o           ( r_ecc_o[p]           ),
      .req_o             ( arb_req[p]           ),
      .gnt_i             ( arb_gnt[p]           ),
      .add_o             ( arb_add[p]           ),
      .wen_o             ( arb_wen[p]           ),
      .be_o              ( arb_be[p]            ),
      .data_o            ( arb_data[p]          ),
      .r_valid_i         ( arb_r_valid[p]       ),
      .r_data_i          ( arb_r_data[p]        ),
      .data_single_err_o ( data_single_err_o[p] ),
      .data_multi_err_o  ( data_multi_err_o[p]  ),
      .meta_single_err_o ( meta_single_err_o[p] ),
      .meta_multi_err_o  ( meta_multi_err_o[p]  )
    );
  end

  tcdm_rr_arbiter i_arbiter (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .req_i          ( arb_req      ),
    .gnt_o          ( arb_gnt      ),
    .add_i          ( arb_add      ),
    .wen_i          ( arb_wen      ),
    .be_i           ( arb_be       ),
    .data_i         ( arb_data     ),
    .r_valid_o      ( arb_r_valid  ),
    .r_data_o       ( arb_r_data   ),
    .bank_req_o     ( bank_req     ),
    .bank_add_o     ( bank_add     ),
    .bank_wen_o     ( bank_wen     ),
    .bank_be_o      ( bank_be      ),
    .bank_data_o    ( bank_data    ),
    .bank_r_valid_i ( bank_r_valid ),
    .bank_r_data_i  ( bank_r_data  )
  );

  tcdm_sram_bank i_bank (
    .clk_i     ( clk_i        ),
    .rst_n_i   ( rst_n_i      ),
    .req_i     ( bank_req     ),
    .add_i     ( bank_add     ),
    .wen_i     ( bank_wen     ),
    .be_i      ( bank_be      ),
    .data_i    ( bank_data    ),
    .r_valid_o ( bank_r_valid ),
    .r_data_o  ( bank_r_data  )
  );

endmodule

`default_nettype wire

//--- design/tcdm_rr_arbiter.sv
// tcdm_rr_arbiter: two-port round-robin arbiter, request mux and response steering
`timescale 1ns/1ps
`default_nettype none

module tcdm_rr_arbiter (
  input  wire logic                                                       clk_i,
  input  wire logic                                                       rst_n_i,
  // initiator ports
  input  wire logic [tcdm_bus_pkg::N_PORTS-1:0]                           req_i,
  output logic      [tcdm_bus_pkg::N_PORTS-1:0]                           gnt_o,
  input  wire logic [tcdm_bus_pkg::N_PORTS-1:0][tcdm_bus_pkg::ADDR_W-1:0] add_i,
  input  wire logic [tcdm_bus_pkg::N_PORTS-1:0]                           wen_i,
  input  wire logic [tcdm_bus_pkg::N_PORTS-1:0][tcdm_bus_pkg::BE_W-1:0]   be_i,
  input  wire logic [tcdm_bus_pkg::N_PORTS-1:0][tcdm_bus_pkg::DATA_W-1:0] data_i,
  output logic      [tcdm_bus_pkg::N_PORTS-1:0]                           r_valid_o,
  output logic      [tcdm_bus_pkg::N_PORTS-1:0][tcdm_bus_pkg::DATA_W-1:0] r_data_o,
  // bank side
  output logic                                                            bank_req_o,
  output logic      [tcdm_bus_pkg::ADDR_W-1:0]                            bank_add_o,
  output logic                                                            bank_wen_o,
  output logic      [tcdm_bus_pkg::BE_W-1:0]                              bank_be_o,
  output logic      [tcdm_bus_pkg::DATA_W-1:0]                            bank_data_o,
  input  wire logic                                                       bank_r_valid_i,
  input  wire logic [tcdm_bus_pkg::DATA_W-1:0]                            bank_r_data_i
);

  import tcdm_bus_pkg::*;

  arb_last_e last_q;
  logic      win;
  logic      resp_port_q;

  // port 1 wins alone, or on a tie when port 0 went last
  assign win = req_i[1] & (~req_i[0] | (last_q == LAST_P0));

  assign gnt_o[0] = req_i[0] & ~win;
  assign gnt_o[1] = req_i[1] & win;

  assign bank_req_o  = |req_i;
  assign bank_add_o  = add_i[win];
  assign bank_wen_o  = wen_i[win];
  assign bank_be_o   = be_i[win];
  assign bank_data_o = data_i[win];

  // priority flips on every grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q      <= LAST_P1;
      resp_port_q <= 1'b0;
    end else if (bank_req_o) begin
      last_q      <= win ? LAST_P1 : LAST_P0;
      resp_port_q <= win;
    end
  end

  // response goes back to the port granted one cycle earlier
  for (genvar p = 0; p < N_PORTS; p++) begin : g_resp
    assign r_valid_o[p] = bank_r_valid_i & (resp_port_q == p);
    assign r_data_o[p]  = (resp_port_q == p) ? bank_r_data_i : '0;
  end

endmodule

`default_nettype wire

//--- design/tcdm_sram_bank.sv
// tcdm_sram_bank: 256-word byte-enabled memory with a one-cycle response
`timescale 1ns/1ps
`default_nettype none

module tcdm_sram_bank (
  input  wire logic                            clk_i,
  input  wire logic                            rst_n_i,
  input  wire logic                            req_i,
  input  wire logic [tcdm_bus_pkg::ADDR_W-1:0] add_i,
  input  wire logic                            wen_i,
  input  wire logic [tcdm_bus_pkg::BE_W-1:0]   be_i,
  input  wire logic [tcdm_bus_pkg::DATA_W-1:0] data_i,
  output logic                                 r_valid_o,
  output logic      [tcdm_bus_pkg::DATA_W-1:0] r_data_o
);

  import tcdm_bus_pkg::*;

  logic [DATA_W-1:0] mem_q [2**ADDR_W];

  // write merges the enabled bytes only, wen_i low means write
  always_ff @(posedge clk_i) begin
    if (req_i && !wen_i) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[add_i][b*(DATA_W/BE_W) +: DATA_W/BE_W] <= data_i[b*(DATA_W/BE_W) +: DATA_W/BE_W];
        end
      end
    end
  end

  // registered read, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      r_data_o <= wen_i ? mem_q[add_i] : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_o <= 1'b0;
    end else begin
      r_valid_o <= req_i;
    end
  end

endmodule

`default_nettype wire

//--- files.f
design/tcdm_bus_pkg.sv
design/tcdm_ecc_pkg.sv
design/hsiao_enc.sv
design/hsiao_dec.sv
design/tcdm_ecc_dec.sv
design/tcdm_rr_arbiter.sv
design/tcdm_sram_bank.sv
design/tcdm_ecc_top.sv
testbench/tb_tcdm_ecc_assert.sv
testbench/tb_tcdm_ecc.sv

//--- testbench/tb_tcdm_ecc.sv
// tb_tcdm_ecc: table-driven testbench with reference SECDED model, memory model and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_ecc;

  import tcdm_bus_pkg::*;
  import tcdm_ecc_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int N_ENTRIES      = 16;
  localparam int TIMEOUT_CYCLES = N_ENTRIES * 6 + 10;

  // exp_flags is {data single, data multi, meta single, meta multi}
  typedef struct packed {
    logic                 port;
    logic                 wen;
    logic [ADDR_W-1:0]    addr;
    logic [BE_W-1:0]      be;
    logic [DATA_W-1:0]    data;
    logic [DATA_W-1:0]    dmask;
    logic [META_W-1:0]    mmask;
    logic [REQ_ECC_W-1:0] emask;
    logic [DATA_W-1:0]    exp_rdata;
    logic [3:0]           exp_flags;
    logic                 both;
    logic                 oth_wen;
    logic [ADDR_W-1:0]    oth_addr;
    logic [DATA_W-1:0]    oth_data;
    logic [DATA_W-1:0]    oth_rdata;
  } entry_t;

  logic                                clk_i;
  logic                                rst_n_i;
  logic [N_PORTS-1:0]                  req_i;
  logic [N_PORTS-1:0]                  gnt_o;
  logic [N_PORTS-1:0][ADDR_W-1:0]      add_i;
  logic [N_PORTS-1:0]                  wen_i;
  logic [N_PORTS-1:0][BE_W-1:0]        be_i;
  logic [N_PORTS-1:0][DATA_W-1:0]      data_i;
  logic [N_PORTS-1:0][REQ_ECC_W-1:0]   ecc_i;
  logic [N_PORTS-1:0]                  r_valid_o;
  logic [N_PORTS-1:0][DATA_W-1:0]      r_data_o;
  logic [N_PORTS-1:0][DATA_ECC_W-1:0]  r_ecc_o;
  logic [N_PORTS-1:0]                  data_single_err_o;
  logic [N_PORTS-1:0]                  data_multi_err_o;
  logic [N_PORTS-1:0]                  meta_single_err_o;
  logic [N_PORTS-1:0]                  meta_multi_err_o;

  entry_t                tbl [N_ENTRIES];
  int                    n_ent;
  int                    last_port;
  logic [DATA_W-1:0]     model_mem [2**ADDR_W];
  logic [DATA_ECC_W-1:0] dcol [DATA_W];
  logic [META_ECC_W-1:0] mcol [META_W];

  tcdm_ecc_top u_dut (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .req_i             ( req_i             ),
    .gnt_o             ( gnt_o             ),
    .add_i             ( add_i             ),
    .wen_i             ( wen_i             ),
    .be_i              ( be_i              ),
    .data_i            ( data_i            ),
    .ecc_i             ( ecc_i             ),
    .r_valid_o         ( r_valid_o         ),
    .r_data_o          ( r_data_o          ),
    .r_ecc_o           ( r_ecc_o           ),
    .data_single_err_o ( data_single_err_o ),
    .data_multi_err_o  ( data_multi_err_o  ),
    .meta_single_err_o ( meta_single_err_o ),
    .meta_multi_err_o  ( meta_multi_err_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_data(input string name, input logic [DATA_W-1:0] act,
                            input logic [DATA_W-1:0] exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
      $display("Errors found");
      $fatal(1, "data compare failed");
    end
  endtask

  task automatic check_ecc(input string name, input logic [DATA_ECC_W-1:0] act,
                           input logic [DATA_ECC_W-1:0] exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
      $display("Errors found");
      $fatal(1, "check-bit compare failed");
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, act, exp);
      $display("Errors found");
      $fatal(1, "flag compare failed");
    end
  endtask

  // odd-weight columns from weight 3 up with smaller values first
  task automatic build_columns();
    int nd;
    int nm;
    nd = 0;
    nm = 0;
    for (int w = 3; w <= DATA_ECC_W; w += 2) begin
      for (int v = 0; v < 2**DATA_ECC_W; v++) begin
        if ($countones(v) == w && nd < DATA_W) begin
          dcol[nd] = v[DATA_ECC_W-1:0];
          nd++;
        end
        if ($countones(v) == w && v < 2**META_ECC_W && nm < META_W) begin
          mcol[nm] = v[META_ECC_W-1:0];
          nm++;
        end
      end
    end
  endtask

  function automatic logic [DATA_ECC_W-1:0] data_check(input logic [DATA_W-1:0] d);
    logic [DATA_ECC_W-1:0] c;
    c = '0;
    for (int i = 0; i < DATA_W; i++) begin
      if (d[i]) begin
        c ^= dcol[i];
      end
    end
    return c;
  endfunction

  function automatic logic [META_ECC_W-1:0] meta_check(input logic [META_W-1:0] m);
    logic [META_ECC_W-1:0] c;
    c = '0;
    for (int i = 0; i < META_W; i++) begin
      if (m[i]) begin
        c ^= mcol[i];
      end
    end
    return c;
  endfunction

  // single errors get corrected and double errors pass through as sent
  task automatic model_access(input logic wen, input logic [ADDR_W-1:0] addr,
                              input logic [BE_W-1:0] be, input logic [DATA_W-1:0] data, dmask,
                              input logic [META_W-1:0] mmask, input logic [REQ_ECC_W-1:0] emask,
                              output logic [DATA_W-1:0] rdata);
    logic [META_W-1:0] meta;
    logic [DATA_W-1:0] d;
    meta = {addr, wen, be};
    d    = data;
    if ($countones(dmask) + $countones(emask[REQ_ECC_W-1:META_ECC_W]) > 1) begin
      d = data ^ dmask;
    end
    if ($countones(mmask) + $countones(emask[META_ECC_W-1:0]) > 1) begin
      meta = meta ^ mmask;
    end
    rdata = '0;
    if (meta[BE_W]) begin
      rdata = model_mem[meta[META_W-1:BE_W+1]];
    end else begin
      for (int b = 0; b < BE_W; b++) begin
        if (meta[b]) begin
          model_mem[meta[META_W-1:BE_W+1]][b*8 +: 8] = d[b*8 +: 8];
        end
      end
    end
  endtask

  task automatic add_req(input logic port, input logic wen, input logic [ADDR_W-1:0] addr,
                         input logic [BE_W-1:0] be, input logic [DATA_W-1:0] data, dmask,
                         input logic [META_W-1:0] mmask, input logic [REQ_ECC_W-1:0] emask,
                         input logic [3:0] flags);
    entry_t e;
    e           = '0;
    e.port      = port;
    e.wen       = wen;
    e.addr      = addr;
    e.be        = be;
    e.data      = data;
    e.dmask     = dmask;
    e.mmask     = mmask;
    e.emask     = emask;
    e.exp_flags = flags;
    model_access(wen, addr, be, data, dmask, mmask, emask, e.exp_rdata);
    tbl[n_ent] = e;
    n_ent++;
  endtask

  // clean full-word request on the other port of the last entry
  task automatic add_other(input logic wen, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] rdata;
    model_access(wen, addr, 4'hf, data, '0, '0, '0, rdata);
    tbl[n_ent-1].both      = 1'b1;
    tbl[n_ent-1].oth_wen   = wen;
    tbl[n_ent-1].oth_addr  = addr;
    tbl[n_ent-1].oth_data  = data;
    tbl[n_ent-1].oth_rdata = rdata;
  endtask

  task automatic build_table();
    n_ent = 0;
    // first tie after reset with both ports writing
    add_req(0, 0, 8'h10, 4'hf, $urandom(), '0, '0, '0, 4'b0000);
    add_other(0, 8'h20, $urandom());
    add_req(0, 1, 8'h10, 4'hf, '0, '0, '0, '0, 4'b0000);
    add_req(1, 0, 8'h21, 4'hf, $urandom(), 32'h0000_0020, '0, '0, 4'b1000);
    add_req(1, 1, 8'h21, 4'hf, '0, '0, '0, '0, 4'b0000);
    // data check bit 2 flipped
    add_req(0, 0, 8'h33, 4'hf, $urandom(), '0, '0, 13'h0100, 4'b1000);
    add_req(0, 1, 8'h33, 4'hf, '0, '0, '0, '0, 4'b0000);
    // address bit 1 flipped
    add_req(1, 0, 8'h44, 4'hf, $urandom(), '0, 13'h0040, '0, 4'b0010);
    add_req(1, 1, 8'h44, 4'hf, '0, '0, '0, '0, 4'b0000);
    add_req(0, 1, 8'h10, 4'hf, $urandom(), 32'h0002_0008, '0, '0, 4'b0100);
    add_req(1, 1, 8'h21, 4'hf, '0, '0, 13'h0003, '0, 4'b0001);
    // partial write of bytes 0 and 2
    add_req(0, 0, 8'h10, 4'b0101, $urandom(), '0, '0, '0, 4'b0000);
    add_req(0, 1, 8'h10, 4'hf, '0, '0, '0, '0, 4'b0000);
    add_req(1, 0, 8'h55, 4'hf, $urandom(), '0, '0, '0, 4'b0000);
    add_other(1, 8'h33, '0);
    add_req(0, 1, 8'h55, 4'hf, '0, '0, '0, '0, 4'b0000);
    add_other(1, 8'h20, '0);
    // metadata check bit 1 flipped
    add_req(1, 1, 8'h44, 4'hf, '0, '0, '0, 13'h0002, 4'b0010);
    add_req(1, 1, 8'h10, 4'hf, '0, '0, '0, '0, 4'b0000);
    add_other(1, 8'h21, '0);
  endtask

  task automatic drive_req(input int p, input logic wen, input logic [ADDR_W-1:0] addr,
                           input logic [BE_W-1:0] be, input logic [DATA_W-1:0] data, dmask,
                           input logic [META_W-1:0] mmask, input logic [REQ_ECC_W-1:0] emask);
    logic [META_W-1:0] meta;
    meta                          = {addr, wen, be};
    req_i[p]                      = 1'b1;
    {add_i[p], wen_i[p], be_i[p]} = meta ^ mmask;
    data_i[p]                     = data ^ dmask;
    ecc_i[p]                      = {data_check(data), meta_check(meta)} ^ emask;
  endtask

  task automatic release_req(input int p);
    req_i[p]  = 1'b0;
    add_i[p]  = '0;
    wen_i[p]  = 1'b0;
    be_i[p]   = '0;
    data_i[p] = '0;
    ecc_i[p]  = '0;
  endtask

  // grant in the current cycle and the response one cycle later
  task automatic serve_port(input int p, input logic [DATA_W-1:0] exp);
    check_flag($sformatf("gnt_o[%0d]", p), gnt_o[p], 1'b1);
    @(posedge clk_i);
    last_port = p;
    @(negedge clk_i);
    release_req(p);
    #(CLK_PERIOD / 4);
    check_flag($sformatf("r_valid_o[%0d]", p), r_valid_o[p], 1'b1);
    check_flag($sformatf("r_valid_o[%0d]", 1 - p), r_valid_o[1 - p], 1'b0);
    check_data($sformatf("r_data_o[%0d]", p), r_data_o[p], exp);
    check_ecc($sformatf("r_ecc_o[%0d]", p), r_ecc_o[p], data_check(exp));
  endtask

  task automatic apply_entry(input int i);
    entry_t e;
    int     p;
    int     first;
    e = tbl[i];
    p = e.port;
    @(negedge clk_i);
    drive_req(p, e.wen, e.addr, e.be, e.data, e.dmask, e.mmask, e.emask);
    if (e.both) begin
      drive_req(1 - p, e.oth_wen, e.oth_addr, 4'hf, e.oth_data, '0, '0, '0);
    end
    #(CLK_PERIOD / 4);
    check_flag($sformatf("data_single_err_o[%0d]", p), data_single_err_o[p], e.exp_flags[3]);
    check_flag($sformatf("data_multi_err_o[%0d]", p), data_multi_err_o[p], e.exp_flags[2]);
    check_flag($sformatf("meta_single_err_o[%0d]", p), meta_single_err_o[p], e.exp_flags[1]);
    check_flag($sformatf("meta_multi_err_o[%0d]", p), meta_multi_err_o[p], e.exp_flags[0]);
    if (e.both) begin
      // the port not granted last wins the tie
      first = 1 - last_port;
      check_flag($sformatf("gnt_o[%0d]", 1 - first), gnt_o[1 - first], 1'b0);
      serve_port(first, (first == p) ? e.exp_rdata : e.oth_rdata);
      serve_port(1 - first, (first == p) ? e.oth_rdata : e.exp_rdata);
    end else begin
      serve_port(p, e.exp_rdata);
    end
  endtask

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    wait (u_dut.u_assert.fail_cnt != 0);
    $display("a bound assertion on the DUT ports failed at %0t", $time);
    $display("Errors found");
    $fatal(1, "assertion failure");
  end

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'h0b0f_9827));
    rst_n_i   = 1'b0;
    req_i     = '0;
    add_i     = '0;
    wen_i     = '0;
    be_i      = '0;
    data_i    = '0;
    ecc_i     = '0;
    last_port = 1;
    build_columns();
    build_table();
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    for (int i = 0; i < n_ent; i++) begin
      apply_entry(i);
    end
    @(negedge clk_i);
    if (u_dut.u_assert.fail_cnt != 0) begin
      $display("%0d bound assertion failures", u_dut.u_assert.fail_cnt);
      $display("Errors found");
      $fatal(1, "assertion failures at end of run");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_tcdm_ecc_assert.sv
// tb_tcdm_ecc_assert: bound checks on grants, response timing and error flags
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_ecc_assert (
  input wire logic                              clk_i,
  input wire logic                              rst_n_i,
  input wire logic [tcdm_bus_pkg::N_PORTS-1:0] req_i,
  input wire logic [tcdm_bus_pkg::N_PORTS-1:0] gnt_i,
  input wire logic [tcdm_bus_pkg::N_PORTS-1:0] r_valid_i,
  input wire logic [tcdm_bus_pkg::N_PORTS-1:0] data_single_err_i,
  input wire logic [tcdm_bus_pkg::N_PORTS-1:0] data_multi_err_i,
  input wire logic [tcdm_bus_pkg::N_PORTS-1:0] meta_single_err_i,
  input wire logic [tcdm_bus_pkg::N_PORTS-1:0] meta_multi_err_i
);

  import tcdm_bus_pkg::*;

  int unsigned fail_cnt;

  initial fail_cnt = 0;

  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gnt_i & ~req_i) == '0)
    else begin
      fail_cnt++;
      $error("grant without request");
    end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(gnt_i))
    else begin
      fail_cnt++;
      $error("more than one grant");
    end

  for (genvar p = 0; p < N_PORTS; p++) begin : g_port
    // response exactly one cycle after the grant
    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      gnt_i[p] |=> r_valid_i[p])
      else begin
        fail_cnt++;
        $error("port %0d: no response after grant", p);
      end

    a_rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_valid_i[p] |-> $past(gnt_i[p]))
      else begin
        fail_cnt++;
        $error("port %0d: response without grant", p);
      end

    a_data_flags: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_i[p] |-> !(data_single_err_i[p] && data_multi_err_i[p]))
      else begin
        fail_cnt++;
        $error("port %0d: data single and multi flags both high", p);
      end

    a_meta_flags: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_i[p] |-> !(meta_single_err_i[p] && meta_multi_err_i[p]))
      else begin
        fail_cnt++;
        $error("port %0d: meta single and multi flags both high", p);
      end
  end

endmodule

bind tcdm_ecc_top tb_tcdm_ecc_assert u_assert (
  .clk_i             ( clk_i             ),
  .rst_n_i           ( rst_n_i           ),
  .req_i             ( req_i             ),
  .gnt_i             ( gnt_o             ),
  .r_valid_i         ( r_valid_o         ),
  .data_single_err_i ( data_single_err_o ),
  .data_multi_err_i  ( data_multi_err_o  ),
  .meta_single_err_i ( meta_single_err_o ),
  .meta_multi_err_i  ( meta_multi_err_o  )
);

`default_nettype wire
